// File: rtl/pov_defines.svh
`ifndef POV_DEFINES_SVH
`define POV_DEFINES_SVH

// panel geometry
`define POV_NUM_COLS      64                          // pixels per shifted line
`define POV_SCAN_RATE     32                          // scan rows, 1:32 panel
`define POV_ADDR_W        ($clog2(`POV_SCAN_RATE))    // row address lines A..E
`define POV_PIX_W         ($clog2(`POV_NUM_COLS))

// colour depth, one BCM plane per bit
`define POV_COLOR_BITS    3
`define POV_PLANE_W       ($clog2(`POV_COLOR_BITS))

// lit time of plane 0 in clk_in cycles
// plane p stays lit for base << p
`define POV_BASE_PERIOD   10

// counter wide enough for the longest plane
`define POV_PERIOD_W      ($clog2((`POV_BASE_PERIOD << (`POV_COLOR_BITS - 1)) + 1))

`endif

// File: rtl/pov_pkg.sv
`include "pov_defines.svh"

package pov_pkg;

   // red in the low bits, same order as the panel connector R,G,B
   typedef struct packed {
      logic [`POV_COLOR_BITS-1:0] blue;
      logic [`POV_COLOR_BITS-1:0] green;
      logic [`POV_COLOR_BITS-1:0] red;
   } pixel_t;

   // one display column, upper half drives rgb0, lower half rgb1
   typedef struct packed {
      pixel_t [`POV_NUM_COLS-1:0] lower;
      pixel_t [`POV_NUM_COLS-1:0] upper;
   } column_pair_t;

   // one bit per colour as seen on the panel pins
   typedef struct packed {
      logic blue;
      logic green;
      logic red;
   } rgb_bits_t;

   typedef logic [`POV_PLANE_W-1:0] plane_t;      // BCM bit plane
   typedef logic [`POV_PIX_W-1:0]   pixel_idx_t;  // pixel within a line

endpackage

// File: rtl/column_buffer.sv
`timescale 1ns/1ps
`include "pov_defines.svh"

module column_buffer (
   input  logic                     clk_in,
   input  logic                     rst_in,
   input  logic                     load,
   input  logic                     frame_done,
   input  pov_pkg::column_pair_t    column_data,
   input  logic [`POV_ADDR_W-1:0]   address_data,
   output pov_pkg::column_pair_t    column_pair,
   output logic [`POV_ADDR_W-1:0]   hub75_address
);

   logic busy;  // held column in use by the current frame

   // payload, captured once per frame
   always_ff @(posedge clk_in) begin
      if (load) begin
         column_pair <= column_data;
      end
   end

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         hub75_address <= '0;
      end else if (load) begin
         hub75_address <= address_data;  // row stays put for all three planes
      end
   end

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         busy <= 1'b0;
      end else if (load) begin
         busy <= 1'b1;
      end else if (frame_done) begin
         busy <= 1'b0;
      end
   end

   // the controller may only reload between frames,
   // otherwise the panel would mix two columns in one frame
   a_load_when_free: assert property (
      @(posedge clk_in) disable iff (rst_in)
      load |-> !busy
   );

   // frame_done closes a frame that was opened by a load
   a_done_when_busy: assert property (
      @(posedge clk_in) disable iff (rst_in)
      frame_done |-> busy
   );

endmodule

// File: rtl/bcm_plane_select.sv
`timescale 1ns/1ps
`include "pov_defines.svh"

module bcm_plane_select (
   input  pov_pkg::column_pair_t  column_pair,
   input  pov_pkg::pixel_idx_t    pixel_idx,
   input  pov_pkg::plane_t        plane,
   output pov_pkg::rgb_bits_t     rgb0,
   output pov_pkg::rgb_bits_t     rgb1
);

   pov_pkg::pixel_t px_upper;
   pov_pkg::pixel_t px_lower;

   // one bit of each colour field, picked by the plane index
   function automatic pov_pkg::rgb_bits_t plane_bits(
      input pov_pkg::pixel_t px,
      input pov_pkg::plane_t p
   );
      pov_pkg::rgb_bits_t bits;
      bits = '0;
      if (p < `POV_COLOR_BITS) begin  // unused plane code gives black
         bits.red   = px.red[p];
         bits.green = px.green[p];
         bits.blue  = px.blue[p];
      end
      return bits;
   endfunction

   // same pixel position in both halves
   assign px_upper = column_pair.upper[pixel_idx];
   assign px_lower = column_pair.lower[pixel_idx];

   assign rgb0 = plane_bits(px_upper, plane);  // rows 0..31
   assign rgb1 = plane_bits(px_lower, plane);  // rows 32..63

endmodule

// File: rtl/bcm_period_timer.sv
`timescale 1ns/1ps
`include "pov_defines.svh"

module bcm_period_timer (
   input  logic             clk_in,
   input  logic             rst_in,
   input  logic             period_start,
   input  pov_pkg::plane_t  plane,
   output logic             period_last
);

   localparam int COUNT_W = `POV_PERIOD_W;

   typedef logic [COUNT_W-1:0] count_t;

   count_t count;    // cycles of lit time left
   logic   running;

   assign running     = (count != '0);
   assign period_last = (count == count_t'(1));  // final lit cycle

   // binary weights 1, 2, 4 times the base period
   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         count <= '0;
      end else if (period_start) begin
         count <= count_t'(`POV_BASE_PERIOD << plane);
      end else if (running) begin
         count <= count - 1'b1;
      end
   end

   // the controller starts a plane only after the previous
   // one has run out
   a_start_when_idle: assert property (
      @(posedge clk_in) disable iff (rst_in)
      period_start |-> !running
   );

endmodule

// File: rtl/hub75_scan_ctrl.sv
`timescale 1ns/1ps
`include "pov_defines.svh"

module hub75_scan_ctrl (
   input  logic                 clk_in,
   input  logic                 rst_in,
   input  logic                 tvalid,
   output logic                 tready,
   output logic                 tlast,
   output logic                 load,
   output pov_pkg::pixel_idx_t  pixel_idx,
   output pov_pkg::plane_t      plane,
   output logic                 period_start,
   input  logic                 period_last,
   output logic                 led_clk,
   output logic                 led_latch,
   output logic                 led_blank
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SHIFT,
      ST_LATCH,
      ST_DISPLAY
   } state_t;

   localparam pov_pkg::pixel_idx_t LAST_PIXEL = pov_pkg::pixel_idx_t'(`POV_NUM_COLS - 1);
   localparam pov_pkg::plane_t     LAST_PLANE = pov_pkg::plane_t'(`POV_COLOR_BITS - 1);

   state_t state;
   state_t state_next;
   logic   clk_mask;    // panel clock enable, changes only while clk_in is low
   logic   last_pixel;
   logic   last_plane;
   logic   plane_done;

   assign last_pixel = (pixel_idx == LAST_PIXEL);
   assign last_plane = (plane == LAST_PLANE);
   assign plane_done = (state == ST_DISPLAY) && period_last;

   // stream side
   assign tready       = (state == ST_IDLE);
   assign load         = tready && tvalid;
   assign tlast        = plane_done && last_plane;
   assign period_start = (state == ST_LATCH);  // timer loads as the latch closes

   always_comb begin
      state_next = state;
      case (state)
         ST_IDLE: begin
            if (load) begin
               state_next = ST_SHIFT;
            end
         end
         ST_SHIFT: begin
            if (last_pixel) begin
               state_next = ST_LATCH;
            end
         end
         ST_LATCH: begin
            state_next = ST_DISPLAY;
         end
         ST_DISPLAY: begin
            if (period_last) begin
               state_next = last_plane ? ST_IDLE : ST_SHIFT;
            end
         end
         default: state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         state     <= ST_IDLE;
         pixel_idx <= '0;
         plane     <= '0;
         led_latch <= 1'b0;
         led_blank <= 1'b1;
      end else begin
         state     <= state_next;
         led_latch <= (state_next == ST_LATCH);
         led_blank <= (state_next != ST_DISPLAY);  // dark while shifting and latching
         if (state == ST_SHIFT) begin
            pixel_idx <= last_pixel ? '0 : pixel_idx + 1'b1;
         end
         if (plane_done) begin
            plane <= last_plane ? '0 : plane + 1'b1;  // next plane or back to plane 0
         end
      end
   end

   // Pixel k is on rgb0/rgb1 for the whole of shift cycle k. The panel
   // takes it on the led_clk rise that ends that cycle, so the mask opens
   // halfway through the first shift cycle and closes halfway through latch.
   always_ff @(negedge clk_in) begin
      if (rst_in) begin
         clk_mask <= 1'b0;
      end else begin
         clk_mask <= (state == ST_SHIFT);
      end
   end

   assign led_clk = clk_in & clk_mask;  // mask only moves in the low phase

   // no panel clock edge at the end of a latch cycle
   a_latch_no_clk: assert property (
      @(posedge clk_in) disable iff (rst_in)
      led_latch |-> !clk_mask
   );

   a_plane_range: assert property (
      @(posedge clk_in) disable iff (rst_in)
      plane <= LAST_PLANE
   );

endmodule

// File: rtl/hub75_output.sv
`timescale 1ns/1ps
`include "pov_defines.svh"

module hub75_output (
   input  logic                     clk_in,
   input  logic                     rst_in,
   input  pov_pkg::column_pair_t    column_data,
   input  logic [`POV_ADDR_W-1:0]   address_data,
   input  logic                     tvalid,
   output logic                     tready,
   output logic                     tlast,
   output pov_pkg::rgb_bits_t       rgb0,
   output pov_pkg::rgb_bits_t       rgb1,
   output logic                     led_clk,
   output logic                     led_latch,
   output logic                     led_blank,
   output logic [`POV_ADDR_W-1:0]   hub75_address
);

   logic                   load;
   logic                   period_start;
   logic                   period_last;
   pov_pkg::pixel_idx_t    pixel_idx;
   pov_pkg::plane_t        plane;
   pov_pkg::column_pair_t  column_pair;  // held copy for the running frame

   hub75_scan_ctrl u_ctrl (
      .clk_in       (clk_in),
      .rst_in       (rst_in),
      .tvalid       (tvalid),
      .tready       (tready),
      .tlast        (tlast),
      .load         (load),
      .pixel_idx    (pixel_idx),
      .plane        (plane),
      .period_start (period_start),
      .period_last  (period_last),
      .led_clk      (led_clk),
      .led_latch    (led_latch),
      .led_blank    (led_blank)
   );

   column_buffer u_buffer (
      .clk_in        (clk_in),
      .rst_in        (rst_in),
      .load          (load),
      .frame_done    (tlast),  // last lit cycle frees the buffer
      .column_data   (column_data),
      .address_data  (address_data),
      .column_pair   (column_pair),
      .hub75_address (hub75_address)
   );

   bcm_plane_select u_select (
      .column_pair (column_pair),
      .pixel_idx   (pixel_idx),
      .plane       (plane),
      .rgb0        (rgb0),
      .rgb1        (rgb1)
   );

   bcm_period_timer u_timer (
      .clk_in       (clk_in),
      .rst_in       (rst_in),
      .period_start (period_start),
      .plane        (plane),
      .period_last  (period_last)
   );

endmodule

// File: dv/hub75_panel_model.sv
`timescale 1ns/1ps
`include "pov_defines.svh"

module hub75_panel_model (
   input  logic                                                      rst_in,
   input  logic                                                      led_clk,
   input  logic                                                      led_latch,
   input  pov_pkg::rgb_bits_t                                        rgb0,
   input  pov_pkg::rgb_bits_t                                        rgb1,
   output pov_pkg::rgb_bits_t [`POV_COLOR_BITS-1:0][`POV_NUM_COLS-1:0] upper_lines,
   output pov_pkg::rgb_bits_t [`POV_COLOR_BITS-1:0][`POV_NUM_COLS-1:0] lower_lines,
   output logic [`POV_COLOR_BITS-1:0][31:0]                          line_pulses,
   output logic [31:0]                                               clk_pulses,
   output logic [31:0]                                               latch_count
);

   pov_pkg::rgb_bits_t [`POV_NUM_COLS-1:0] shift_upper;
   pov_pkg::rgb_bits_t [`POV_NUM_COLS-1:0] shift_lower;
   logic [31:0] pulse_total = '0;
   logic [31:0] latch_total = '0;
   logic [31:0] pulses_at_latch = '0;  // pulse_total at the previous latch
   int          plane_cnt = 0;         // plane the next latch belongs to

   assign clk_pulses  = pulse_total;
   assign latch_count = latch_total;

   // first pixel shifted in ends up at index 0 after a full line
   always @(posedge led_clk) begin
      shift_upper <= {rgb0, shift_upper[`POV_NUM_COLS-1:1]};
      shift_lower <= {rgb1, shift_lower[`POV_NUM_COLS-1:1]};
      pulse_total <= pulse_total + 1;
   end

   // line is taken as the latch closes, no shift edge at that point
   always @(negedge led_latch or posedge rst_in) begin
      if (rst_in) begin
         plane_cnt       <= 0;
         latch_total     <= '0;
         pulses_at_latch <= pulse_total;
      end else begin
         upper_lines[plane_cnt] <= shift_upper;
         lower_lines[plane_cnt] <= shift_lower;
         line_pulses[plane_cnt] <= pulse_total - pulses_at_latch;
         pulses_at_latch        <= pulse_total;
         latch_total            <= latch_total + 1;
         plane_cnt <= (plane_cnt == `POV_COLOR_BITS - 1) ? 0 : plane_cnt + 1;
      end
   end

endmodule

// File: dv/hub75_tb.sv
`timescale 1ns/1ps
`include "pov_defines.svh"

module hub75_tb;

   // shift plus latch per plane, then lit time 1+2+4 times the base period
   localparam int FRAME_CYCLES = `POV_COLOR_BITS * (`POV_NUM_COLS + 1)
                                 + `POV_BASE_PERIOD * ((1 << `POV_COLOR_BITS) - 1);
   localparam int WATCHDOG_CYCLES = 8 * FRAME_CYCLES + 500;  // 8 frames, idle time, reset

   typedef pov_pkg::rgb_bits_t [`POV_NUM_COLS-1:0] line_t;

   logic                           clk_in;
   logic                           rst_in;
   pov_pkg::column_pair_t          column_data;
   logic [`POV_ADDR_W-1:0]         address_data;
   logic                           tvalid;
   logic                           tready;
   logic                           tlast;
   pov_pkg::rgb_bits_t             rgb0;
   pov_pkg::rgb_bits_t             rgb1;
   logic                           led_clk;
   logic                           led_latch;
   logic                           led_blank;
   logic [`POV_ADDR_W-1:0]         hub75_address;
   line_t [`POV_COLOR_BITS-1:0]    upper_lines;
   line_t [`POV_COLOR_BITS-1:0]    lower_lines;
   logic [`POV_COLOR_BITS-1:0][31:0] line_pulses;
   logic [31:0]                    clk_pulses;
   logic [31:0]                    latch_count;

   logic [31:0] lcg_state = 32'hab34;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   // what run_frame saw during the last frame
   int                      ready_low;
   int                      tlast_count;
   int                      tlast_cycle;
   logic                    tlast_blank;
   int                      addr_errs;
   logic [`POV_ADDR_W-1:0]  addr_seen;
   int                      blank_runs[$];
   logic [31:0]             latches_before;

   hub75_output u_dut (
      .clk_in        (clk_in),
      .rst_in        (rst_in),
      .column_data   (column_data),
      .address_data  (address_data),
      .tvalid        (tvalid),
      .tready        (tready),
      .tlast         (tlast),
      .rgb0          (rgb0),
      .rgb1          (rgb1),
      .led_clk       (led_clk),
      .led_latch     (led_latch),
      .led_blank     (led_blank),
      .hub75_address (hub75_address)
   );

   hub75_panel_model u_panel (
      .rst_in      (rst_in),
      .led_clk     (led_clk),
      .led_latch   (led_latch),
      .rgb0        (rgb0),
      .rgb1        (rgb1),
      .upper_lines (upper_lines),
      .lower_lines (lower_lines),
      .line_pulses (line_pulses),
      .clk_pulses  (clk_pulses),
      .latch_count (latch_count)
   );

   initial begin
      clk_in = 1'b0;
      forever #4 clk_in = ~clk_in;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_in);
      $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic pov_pkg::column_pair_t random_column();
      pov_pkg::column_pair_t col;
      for (int i = 0; i < $bits(col) / 32; i++) begin
         col[i*32 +: 32] = next_rand();
      end
      return col;
   endfunction

   // bit p of every colour field, one entry per pixel
   function automatic line_t plane_line(input pov_pkg::pixel_t [`POV_NUM_COLS-1:0] half,
                                        input int p);
      line_t line;
      for (int k = 0; k < `POV_NUM_COLS; k++) begin
         line[k].red   = half[k].red[p];
         line[k].green = half[k].green[p];
         line[k].blue  = half[k].blue[p];
      end
      return line;
   endfunction

   task automatic report_mismatch(input string test, input string what,
                                  input logic [255:0] exp, input logic [255:0] act);
      errors++;
      $display("FAIL %s: %s expected %0h actual %0h", test, what, exp, act);
   endtask

   task automatic close_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", name, errors - errs_before);
      end
   endtask

   // hand one column over and follow it cycle by cycle until tready is back
   task automatic run_frame(input pov_pkg::column_pair_t col,
                            input logic [`POV_ADDR_W-1:0] addr,
                            input bit keep_valid, input bit scramble);
      int          run;
      logic [31:0] r;
      run         = 0;
      ready_low   = 0;
      tlast_count = 0;
      tlast_cycle = 0;
      tlast_blank = 1'b1;
      addr_errs   = 0;
      addr_seen   = addr;
      blank_runs.delete();
      latches_before = latch_count;
      while (tready !== 1'b1) @(negedge clk_in);
      column_data  = col;
      address_data = addr;
      tvalid       = 1'b1;
      @(negedge clk_in);
      if (!keep_valid) tvalid = 1'b0;
      while (tready === 1'b0) begin
         ready_low++;
         if (!led_blank) begin
            run++;
         end else if (run != 0) begin
            blank_runs.push_back(run);
            run = 0;
         end
         if (tlast) begin
            tlast_count++;
            tlast_cycle = ready_low;
            tlast_blank = led_blank;
         end
         if (hub75_address !== addr) begin
            addr_errs++;
            addr_seen = hub75_address;
         end
         if (scramble) begin  // source moves on while the frame runs
            r            = next_rand();
            column_data  = random_column();
            address_data = r[`POV_ADDR_W-1:0];
         end
         @(negedge clk_in);
      end
      if (run != 0) blank_runs.push_back(run);
   endtask

   task automatic check_planes(input string test, input pov_pkg::column_pair_t col);
      line_t exp_line;
      for (int p = 0; p < `POV_COLOR_BITS; p++) begin
         exp_line = plane_line(col.upper, p);
         if (upper_lines[p] !== exp_line) begin
            report_mismatch(test, $sformatf("plane %0d upper", p),
                            256'(exp_line), 256'(upper_lines[p]));
         end
         exp_line = plane_line(col.lower, p);
         if (lower_lines[p] !== exp_line) begin
            report_mismatch(test, $sformatf("plane %0d lower", p),
                            256'(exp_line), 256'(lower_lines[p]));
         end
         if (line_pulses[p] !== 32'(`POV_NUM_COLS)) begin
            report_mismatch(test, $sformatf("plane %0d led_clk pulses", p),
                            256'(`POV_NUM_COLS), 256'(line_pulses[p]));
         end
      end
   endtask

   task automatic test_reset_state();
      int          errs_before;
      int          bad_cycles;
      logic [31:0] pulses_before;
      errs_before   = errors;
      bad_cycles    = 0;
      pulses_before = clk_pulses;
      repeat (20) begin
         if (tready !== 1'b1 || led_latch !== 1'b0 || tlast !== 1'b0 || led_blank !== 1'b1) begin
            bad_cycles++;
         end
         @(negedge clk_in);
      end
      if (bad_cycles != 0) begin
         report_mismatch("reset_state", "idle cycles with wrong strobes", 0, 256'(bad_cycles));
      end
      if (clk_pulses !== pulses_before) begin
         report_mismatch("reset_state", "led_clk pulse count", 256'(pulses_before),
                         256'(clk_pulses));
      end
      close_test("reset_state", errs_before);
   endtask

   task automatic test_pixel_data();
      int                    errs_before;
      pov_pkg::column_pair_t col;
      logic [31:0]           r;
      errs_before = errors;
      col = random_column();
      r   = next_rand();
      run_frame(col, r[`POV_ADDR_W-1:0], 1'b0, 1'b0);
      check_planes("pixel_data", col);
      if (latch_count - latches_before !== 32'(`POV_COLOR_BITS)) begin
         report_mismatch("pixel_data", "latches per frame", 256'(`POV_COLOR_BITS),
                         256'(latch_count - latches_before));
      end
      close_test("pixel_data", errs_before);
   endtask

   task automatic test_address_hold();
      int                    errs_before;
      pov_pkg::column_pair_t col;
      logic [31:0]           r;
      errs_before = errors;
      col = random_column();
      r   = next_rand();
      run_frame(col, r[`POV_ADDR_W-1:0], 1'b0, 1'b1);
      if (addr_errs != 0) begin
         report_mismatch("address_hold", "hub75_address", 256'(r[`POV_ADDR_W-1:0]),
                         256'(addr_seen));
      end
      check_planes("address_hold", col);
      close_test("address_hold", errs_before);
   endtask

   task automatic test_display_weights();
      int errs_before;
      errs_before = errors;
      run_frame(random_column(), 5'd7, 1'b0, 1'b0);
      if (blank_runs.size() != `POV_COLOR_BITS) begin
         report_mismatch("display_weights", "lit periods", 256'(`POV_COLOR_BITS),
                         256'(blank_runs.size()));
      end else begin
         for (int p = 0; p < `POV_COLOR_BITS; p++) begin
            if (blank_runs[p] != `POV_BASE_PERIOD * (2 ** p)) begin
               report_mismatch("display_weights", $sformatf("plane %0d lit cycles", p),
                               256'(`POV_BASE_PERIOD * (2 ** p)), 256'(blank_runs[p]));
            end
         end
      end
      if (ready_low != FRAME_CYCLES) begin
         report_mismatch("display_weights", "tready low cycles", 256'(FRAME_CYCLES),
                         256'(ready_low));
      end
      close_test("display_weights", errs_before);
   endtask

   task automatic test_end_of_frame();
      int errs_before;
      errs_before = errors;
      run_frame(random_column(), 5'd30, 1'b0, 1'b0);
      if (tlast_count != 1) begin
         report_mismatch("end_of_frame", "tlast cycles", 1, 256'(tlast_count));
      end
      // last tready-low cycle, so tready is up right after it
      if (tlast_cycle != ready_low) begin
         report_mismatch("end_of_frame", "tlast cycle", 256'(ready_low), 256'(tlast_cycle));
      end
      if (tlast_blank !== 1'b0) begin
         report_mismatch("end_of_frame", "led_blank at tlast", 0, 256'(tlast_blank));
      end
      close_test("end_of_frame", errs_before);
   endtask

   task automatic test_back_to_back();
      int                    errs_before;
      pov_pkg::column_pair_t col;
      logic [31:0]           r;
      errs_before = errors;
      for (int f = 0; f < 4; f++) begin
         col = random_column();
         r   = next_rand();
         run_frame(col, r[`POV_ADDR_W-1:0], 1'b1, 1'b1);  // tvalid never drops
         if (ready_low != FRAME_CYCLES) begin
            report_mismatch("back_to_back", $sformatf("frame %0d tready low cycles", f),
                            256'(FRAME_CYCLES), 256'(ready_low));
         end
         if (addr_errs != 0) begin
            report_mismatch("back_to_back", $sformatf("frame %0d hub75_address", f),
                            256'(r[`POV_ADDR_W-1:0]), 256'(addr_seen));
         end
         check_planes($sformatf("back_to_back frame %0d", f), col);
      end
      tvalid = 1'b0;
      close_test("back_to_back", errs_before);
   endtask

   initial begin
      rst_in       = 1'b1;
      tvalid       = 1'b0;
      column_data  = '0;
      address_data = '0;
      repeat (10) @(posedge clk_in);
      @(negedge clk_in);
      rst_in = 1'b0;
      test_reset_state();
      test_pixel_data();
      test_address_hold();
      test_display_weights();
      test_end_of_frame();
      test_back_to_back();
      $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+rtl
rtl/pov_pkg.sv
rtl/column_buffer.sv
rtl/bcm_plane_select.sv
rtl/bcm_period_timer.sv
rtl/hub75_scan_ctrl.sv
rtl/hub75_output.sv
dv/hub75_panel_model.sv
dv/hub75_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module hub75_tb -f verilog.f

run: build
	@out=$$(./obj_dir/Vhub75_tb); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only -Wall --timing --assert -Irtl --top-module hub75_output \
		rtl/pov_pkg.sv rtl/column_buffer.sv rtl/bcm_plane_select.sv \
		rtl/bcm_period_timer.sv rtl/hub75_scan_ctrl.sv rtl/hub75_output.sv

clean:
	rm -rf obj_dir
